// File: project.f
source/mem_pkg.sv
source/cache_pkg.sv
source/cache_way.sv
source/cache_controller.sv
source/banked_memory.sv
source/mem_system.sv
dv/mem_system_tb.sv

// File: Makefile
# Verilator build and run for the two-way cache memory system

VERILATOR ?= verilator
TOP ?= mem_system_tb
FILELIST ?= project.f
BUILD_DIR ?= obj_dir
JOBS ?= 0
VFLAGS ?= --binary --timing --assert -Wno-fatal -j $(JOBS)
EXTRA_FLAGS ?=

SOURCES := $(wildcard source/*.sv) $(wildcard dv/*.sv)
SIM_BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(SIM_BIN)

$(SIM_BIN): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) $(EXTRA_FLAGS) --top-module $(TOP) \
		--Mdir $(BUILD_DIR) -f $(FILELIST)

run: compile
	./$(SIM_BIN)

clean:
	rm -rf $(BUILD_DIR)

// File: dv/mem_system_tb.sv
`timescale 1ns/10ps
`default_nettype none

module mem_system_tb;

	import mem_pkg::*;

	localparam int index_bits = 8;
	localparam int tag_bits = 13 - index_bits;
	localparam int lines = 1 << index_bits;
	localparam int clk_period = 20;
	localparam int reset_cycles = 16;
	localparam int n_directed = 13;
	localparam int n_random = 80;
	localparam int n_requests = n_directed + n_random;

	logic clk;
	logic reset;
	addr_t addr;
	word_t data_in;
	logic rd;
	logic wr;
	logic done;
	word_t data_out;
	logic stall;
	logic cache_hit;
	logic err;

	word_t ref_mem [32768];	// CPU view, last value written per word
	logic [tag_bits-1:0] m_tag [2][lines];
	logic m_valid [2][lines];
	logic m_dirty [2][lines];
	logic m_victim;

	logic req_active;	// Request held on the CPU side
	int age;	// Cycles since t0
	int exp_lat;
	logic exp_hit;
	logic exp_err;
	logic check_data;
	word_t exp_data;
	int unsigned seed_val;

	mem_system #(.index_bits(index_bits)) u_mem_system (
		.clk(clk), .reset(reset),
		.addr(addr), .data_in(data_in), .rd(rd), .wr(wr),
		.done(done), .data_out(data_out), .stall(stall),
		.cache_hit(cache_hit), .err(err)
	);

	initial begin
		clk = 1'b0;
		forever #(clk_period / 2) clk = ~clk;
	end

	always @(posedge clk) begin
		if (reset || !req_active || done)
			age <= 0;
		else
			age <= age + 1;
	end

	task automatic halt_on_error(input string msg);
		$display("%s", msg);
		$display("tests failed");
		$fatal(1, "simulation stopped at first error");
	endtask

	function automatic addr_t make_addr(input int tag, input int index, input int word);
		return addr_t'((tag << (16 - tag_bits)) | (index << 3) | (word << 1));
	endfunction

	// Reference model of the cache state and CPU visible memory
	function automatic void predict(input logic r, input logic w, input addr_t a,
			input word_t d);
		int idx;
		int way;
		logic [tag_bits-1:0] tg;
		exp_err = (r && w) || a[0];
		exp_hit = 1'b0;
		check_data = 1'b0;
		exp_lat = 1;
		if (exp_err)
			return;	// No state change at all
		m_victim = ~m_victim;
		idx = int'(a[3 +: index_bits]);
		tg = a[15 -: tag_bits];
		way = -1;
		for (int i = 0; i < 2; i++) begin
			if (m_valid[i][idx] && m_tag[i][idx] == tg)
				way = i;
		end
		if (way >= 0) begin
			exp_hit = 1'b1;
		end else begin
			way = !m_valid[0][idx] ? 0 : !m_valid[1][idx] ? 1 : int'(m_victim);
			exp_lat = (m_valid[way][idx] && m_dirty[way][idx]) ? 13 : 9;	// Write-back first
			m_valid[way][idx] = 1'b1;
			m_tag[way][idx] = tg;
			m_dirty[way][idx] = 1'b0;
		end
		if (w) begin
			m_dirty[way][idx] = 1'b1;
			ref_mem[a[15:1]] = d;
		end else begin
			check_data = 1'b1;
			exp_data = ref_mem[a[15:1]];
		end
	endfunction

	task automatic issue_request(input logic r, input logic w, input addr_t a, input word_t d);
		int waited;
		@(negedge clk);
		rd = r;
		wr = w;
		addr = a;
		data_in = d;
		predict(r, w, a, d);
		req_active = 1'b1;
		waited = 0;
		do begin
			@(negedge clk);
			waited++;
		end while (!done && waited < 16);
		if (!done)
			halt_on_error("no done seen within 16 cycles of a request");
	endtask

	task automatic release_bus();
		@(negedge clk);
		rd = 1'b0;
		wr = 1'b0;
		req_active = 1'b0;
	endtask

	a_quiet_when_idle: assert property (@(posedge clk) disable iff (reset)
		!req_active |-> !done && !stall && !err)
		else halt_on_error($sformatf("FAIL done/stall/err with no request: %h %h %h",
			$sampled(done), $sampled(stall), $sampled(err)));

	a_done_time: assert property (@(posedge clk) disable iff (reset)
		req_active |-> (done == (age == exp_lat)))
		else halt_on_error($sformatf("FAIL done: got %h expected %h at cycle t%0d",
			$sampled(done), $sampled(age) == $sampled(exp_lat), $sampled(age)));

	a_stall: assert property (@(posedge clk) disable iff (reset)
		req_active |-> (stall == (age != 0 && age != exp_lat)))
		else halt_on_error($sformatf("FAIL stall: got %h expected %h at cycle t%0d",
			$sampled(stall), $sampled(age) != 0 && $sampled(age) != $sampled(exp_lat),
			$sampled(age)));

	a_err: assert property (@(posedge clk) disable iff (reset)
		(req_active && done) |-> err == exp_err)
		else halt_on_error($sformatf("FAIL err: got %h expected %h",
			$sampled(err), $sampled(exp_err)));

	a_hit: assert property (@(posedge clk) disable iff (reset)
		(req_active && done) |-> cache_hit == exp_hit)
		else halt_on_error($sformatf("FAIL cache_hit: got %h expected %h",
			$sampled(cache_hit), $sampled(exp_hit)));

	a_data: assert property (@(posedge clk) disable iff (reset)
		(req_active && done && check_data) |-> data_out == exp_data)
		else halt_on_error($sformatf("FAIL data_out: got %h expected %h at addr %h",
			$sampled(data_out), $sampled(exp_data), $sampled(addr)));

	initial begin
		#((n_requests * 14 + reset_cycles + 4) * clk_period);
		halt_on_error("watchdog expired before all requests completed");
	end

	initial begin
		int kind;
		addr_t a;
		word_t d;
		seed_val = $urandom(32'h17da61f4);
		reset = 1'b1;
		rd = 1'b0;
		wr = 1'b0;
		addr = '0;
		data_in = '0;
		req_active = 1'b0;
		m_victim = 1'b0;
		for (int i = 0; i < 32768; i++)
			ref_mem[i] = '0;
		for (int i = 0; i < lines; i++) begin
			for (int w = 0; w < 2; w++) begin
				m_tag[w][i] = '0;
				m_valid[w][i] = 1'b0;
				m_dirty[w][i] = 1'b0;
			end
		end
		repeat (reset_cycles) @(posedge clk);
		@(negedge clk);
		reset = 1'b0;

		issue_request(1'b1, 1'b0, 16'h0100, 16'h0000);	// Cold miss reads zero
		issue_request(1'b0, 1'b1, 16'h0102, 16'hbeef);
		issue_request(1'b1, 1'b0, 16'h0102, 16'h0000);	// Hit with written data

		// Three tags sharing index 5
		issue_request(1'b0, 1'b1, make_addr(1, 5, 0), 16'h1111);
		issue_request(1'b0, 1'b1, make_addr(2, 5, 1), 16'h2222);
		issue_request(1'b1, 1'b0, make_addr(3, 5, 0), 16'h0000);
		issue_request(1'b1, 1'b0, make_addr(1, 5, 0), 16'h0000);	// Back from memory
		issue_request(1'b1, 1'b0, make_addr(2, 5, 1), 16'h0000);

		issue_request(1'b1, 1'b1, make_addr(1, 5, 0), 16'hdead);
		issue_request(1'b1, 1'b0, make_addr(1, 5, 0) | 16'h0001, 16'h0000);
		issue_request(1'b0, 1'b1, make_addr(3, 5, 2) | 16'h0001, 16'hdead);
		issue_request(1'b1, 1'b0, make_addr(1, 5, 0), 16'h0000);
		issue_request(1'b1, 1'b0, make_addr(3, 5, 2), 16'h0000);

		// Random mix over four tags and two indexes
		for (int n = 0; n < n_random; n++) begin
			kind = $urandom_range(9);
			a = make_addr($urandom_range(3), 5 + $urandom_range(1), $urandom_range(3));
			d = word_t'($urandom);
			if (kind == 0)
				issue_request(1'b1, 1'b1, a, d);
			else if (kind == 1)
				issue_request(1'b1, 1'b0, a | 16'h0001, d);
			else
				issue_request(kind[0], !kind[0], a, d);
		end

		release_bus();
		repeat (2) @(negedge clk);
		$display("all tests passed");
		$finish;
	end

endmodule

`default_nettype wire

// File: source/mem_system.sv
`timescale 1ns/10ps
`default_nettype none

module mem_system #(
	parameter int index_bits = 8
) (
	input wire logic clk,
	input wire logic reset,
	input wire mem_pkg::addr_t addr,
	input wire mem_pkg::word_t data_in,
	input wire logic rd,
	input wire logic wr,
	output logic done,
	output mem_pkg::word_t data_out,
	output logic stall,
	output logic cache_hit,
	output logic err
);

	import mem_pkg::*;
	import cache_pkg::*;

	localparam int tag_bits = 13 - index_bits;

	way_sel_t way_hit;
	way_sel_t way_valid;
	way_sel_t way_dirty;
	way_sel_t way_enable;
	logic [tag_bits-1:0] way_tag [2];
	word_t way_data [2];
	logic comp;
	logic write;
	logic data_src;
	offset_t offset;
	addr_t mem_addr;
	word_t mem_wdata;
	word_t mem_rdata;
	logic mem_rd;
	logic mem_wr;

	cache_controller #(.index_bits(index_bits)) u_cache_controller (
		.clk(clk), .reset(reset),
		.addr(addr), .data_in(data_in), .rd(rd), .wr(wr),
		.way_hit(way_hit), .way_valid(way_valid), .way_dirty(way_dirty),
		.way0_tag(way_tag[0]), .way1_tag(way_tag[1]),
		.way0_data(way_data[0]), .way1_data(way_data[1]),
		.mem_rdata(mem_rdata),
		.done(done), .stall(stall), .cache_hit(cache_hit), .err(err),
		.data_out(data_out),
		.way_enable(way_enable), .comp(comp), .write(write),
		.data_src(data_src), .offset(offset),
		.mem_addr(mem_addr), .mem_wdata(mem_wdata),
		.mem_rd(mem_rd), .mem_wr(mem_wr)
	);

	for (genvar w = 0; w < 2; w++) begin : g_way
		cache_way #(.index_bits(index_bits)) u_cache_way (
			.clk(clk), .reset(reset),
			.enable(way_enable[w]), .comp(comp), .write(write),
			.data_src(data_src),
			.index(addr[3 +: index_bits]),	// Index and tag come straight from the CPU
			.tag_in(addr[15 -: tag_bits]),
			.offset(offset), .cpu_data(data_in), .fill_data(mem_rdata),
			.hit(way_hit[w]), .valid(way_valid[w]), .dirty(way_dirty[w]),
			.tag_out(way_tag[w]), .data_out(way_data[w])
		);
	end

	banked_memory u_banked_memory (
		.clk(clk), .reset(reset),
		.mem_addr(mem_addr), .mem_wdata(mem_wdata),
		.mem_rd(mem_rd), .mem_wr(mem_wr),
		.mem_rdata(mem_rdata)
	);

endmodule

`default_nettype wire

// File: source/banked_memory.sv
`timescale 1ns/10ps
`default_nettype none

module banked_memory (
	input wire logic clk,
	input wire logic reset,
	input wire mem_pkg::addr_t mem_addr,
	input wire mem_pkg::word_t mem_wdata,
	input wire logic mem_rd,
	input wire logic mem_wr,
	output mem_pkg::word_t mem_rdata
);

	import mem_pkg::*;

	bank_t bank;
	row_t row;

	word_t bank_mem [4][bank_rows];
	logic [bank_rows-1:0] row_live [4];	// Row written since reset

	word_t rd_word;
	word_t rd_pipe [mem_latency];

	assign bank = mem_addr[2:1];	// Consecutive words hit different banks
	assign row = mem_addr[15:3];

	always_ff @(posedge clk) begin
		if (mem_wr)
			bank_mem[bank][row] <= mem_wdata;
	end

	// Clearing the live bits makes every row read back as zero
	always_ff @(posedge clk) begin
		if (reset) begin
			for (int b = 0; b < 4; b++)
				row_live[b] <= '0;
		end else if (mem_wr) begin
			row_live[bank][row] <= 1'b1;
		end
	end

	assign rd_word = (mem_rd && row_live[bank][row]) ? bank_mem[bank][row] : '0;

	// Read pipeline, one new read may enter every cycle
	always_ff @(posedge clk) begin
		rd_pipe[0] <= rd_word;
		for (int s = 1; s < mem_latency; s++)
			rd_pipe[s] <= rd_pipe[s-1];
	end

	assign mem_rdata = rd_pipe[mem_latency-1];

	a_rd_wr_excl: assert property (
		@(posedge clk) disable iff (reset) !(mem_rd && mem_wr)
	) else $error("banked_memory read and write in one cycle");

endmodule

`default_nettype wire

// File: source/cache_controller.sv
`timescale 1ns/10ps
`default_nettype none

module cache_controller #(
	parameter int index_bits = 8
) (
	input wire logic clk,
	input wire logic reset,
	input wire mem_pkg::addr_t addr,
	input wire mem_pkg::word_t data_in,
	input wire logic rd,
	input wire logic wr,
	input wire cache_pkg::way_sel_t way_hit,
	input wire cache_pkg::way_sel_t way_valid,
	input wire cache_pkg::way_sel_t way_dirty,
	input wire logic [12-index_bits:0] way0_tag,
	input wire logic [12-index_bits:0] way1_tag,
	input wire mem_pkg::word_t way0_data,
	input wire mem_pkg::word_t way1_data,
	input wire mem_pkg::word_t mem_rdata,
	output logic done,
	output logic stall,
	output logic cache_hit,
	output logic err,
	output mem_pkg::word_t data_out,
	output cache_pkg::way_sel_t way_enable,
	output logic comp,
	output logic write,
	output logic data_src,
	output mem_pkg::offset_t offset,
	output mem_pkg::addr_t mem_addr,
	output mem_pkg::word_t mem_wdata,
	output logic mem_rd,
	output logic mem_wr
);

	import mem_pkg::*;
	import cache_pkg::*;

	localparam int tag_bits = 13 - index_bits;

	ctrl_state_t state, next_state;
	logic victim;
	logic bad_req;
	way_sel_t sel_way;
	way_sel_t pick_way;
	logic any_hit;
	logic req_seen;
	logic malformed;
	logic [tag_bits-1:0] victim_tag;
	logic [tag_bits-1:0] mem_tag;
	offset_t mem_offset;
	word_t sel_data;

	assign req_seen = rd | wr;
	assign malformed = (rd & wr) | addr[0];
	assign any_hit = |way_hit;

	// Invalid way 0 first, then invalid way 1, then the victim bit
	assign pick_way = !way_valid[0] ? way_0 :
		!way_valid[1] ? way_1 :
		victim ? way_1 : way_0;

	assign victim_tag = sel_way[1] ? way1_tag : way0_tag;
	assign sel_data = sel_way[1] ? way1_data : way0_data;

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= idle;
			victim <= 1'b0;
			bad_req <= 1'b0;
			sel_way <= way_none;
		end else begin
			state <= next_state;
			if (state == idle && req_seen) begin
				bad_req <= malformed;
				if (!malformed)
					victim <= ~victim;	// Flips on each good request
			end
			if (state == select_way)
				sel_way <= pick_way;
		end
	end

	always_comb begin
		next_state = state;
		case (state)
			idle:
				if (req_seen)
					next_state = compare;
			compare:
				if (bad_req || any_hit)
					next_state = idle;
				else
					next_state = select_way;
			select_way:
				if (|(pick_way & way_valid & way_dirty))
					next_state = wb_0;	// Dirty victim goes back first
				else
					next_state = req_0;
			wb_0: next_state = wb_1;
			wb_1: next_state = wb_2;
			wb_2: next_state = wb_3;
			wb_3: next_state = req_0;
			req_0: next_state = req_1;
			req_1: next_state = req_2_fill_0;
			req_2_fill_0: next_state = req_3_fill_1;
			req_3_fill_1: next_state = fill_2;
			fill_2: next_state = fill_3;
			fill_3: next_state = finish;
			finish: next_state = idle;
			default: next_state = idle;
		endcase
	end

	always_comb begin
		way_enable = way_none;
		comp = 1'b0;
		write = 1'b0;
		data_src = 1'b0;
		offset = addr[2:0];
		mem_rd = 1'b0;
		mem_wr = 1'b0;
		mem_tag = addr[15 -: tag_bits];
		mem_offset = 3'b000;
		case (state)
			compare: begin
				way_enable = bad_req ? way_none : way_both;
				comp = 1'b1;
				write = wr & ~bad_req;
			end
			wb_0, wb_1, wb_2, wb_3: begin
				way_enable = sel_way;
				mem_wr = 1'b1;
				mem_tag = victim_tag;	// Victim line address
				mem_offset = {2'(state - wb_0), 1'b0};
				offset = mem_offset;
			end
			req_0, req_1: begin
				mem_rd = 1'b1;
				mem_offset = {2'(state - req_0), 1'b0};
			end
			req_2_fill_0, req_3_fill_1: begin
				mem_rd = 1'b1;
				mem_offset = {2'(state - req_0), 1'b0};
				way_enable = sel_way;
				write = 1'b1;
				data_src = 1'b1;
				offset = {2'(state - req_2_fill_0), 1'b0};
			end
			fill_2, fill_3: begin
				way_enable = sel_way;
				write = 1'b1;
				data_src = 1'b1;
				offset = {2'(state - req_2_fill_0), 1'b0};
			end
			finish: begin
				way_enable = sel_way;
				comp = 1'b1;
				write = wr;	// Write now hits the filled line
			end
			default: ;
		endcase
	end

	assign mem_addr = {mem_tag, addr[3 +: index_bits], mem_offset};
	assign mem_wdata = sel_data;

	assign done = (state == compare && (bad_req || any_hit)) || state == finish;
	// Busy through a miss, from compare up to the last fill
	assign stall = (state == compare) ? !(bad_req || any_hit) :
		(state != idle) && (state != finish);
	assign err = (state == compare) && bad_req;
	assign cache_hit = (state == compare) && !bad_req && any_hit;
	assign data_out = (state == finish) ? sel_data :
		way_hit[1] ? way1_data : way0_data;

	a_done_stall: assert property (
		@(posedge clk) disable iff (reset) !(done && stall)
	) else $error("done and stall both high");

	a_mem_excl: assert property (
		@(posedge clk) disable iff (reset) !(mem_rd && mem_wr)
	) else $error("mem_rd and mem_wr both high");

	a_idle_hold: assert property (
		@(posedge clk) disable iff (reset)
		(state == idle && !req_seen) |=> state == idle
	) else $error("left idle without a request");

	// Fill data arrives mem_latency cycles after each read
	a_fill_timing: assert property (
		@(posedge clk) disable iff (reset)
		(state == req_0) |-> ##mem_latency (state == req_2_fill_0)
	) else $error("fill sequence out of step with memory latency");

	// Write data must be known when a write is accepted
	a_wr_data_known: assert property (
		@(posedge clk) disable iff (reset)
		(state == idle && wr && !rd) |-> !$isunknown(data_in)
	) else $error("write data unknown");

endmodule

`default_nettype wire

// File: source/cache_way.sv
`timescale 1ns/10ps
`default_nettype none

module cache_way #(
	parameter int index_bits = 8
) (
	input wire logic clk,
	input wire logic reset,
	input wire logic enable,
	input wire logic comp,
	input wire logic write,
	input wire logic data_src,
	input wire logic [index_bits-1:0] index,
	input wire logic [12-index_bits:0] tag_in,
	input wire mem_pkg::offset_t offset,
	input wire mem_pkg::word_t cpu_data,
	input wire mem_pkg::word_t fill_data,
	output logic hit,
	output logic valid,
	output logic dirty,
	output logic [12-index_bits:0] tag_out,
	output mem_pkg::word_t data_out
);

	import mem_pkg::*;

	localparam int tag_bits = 13 - index_bits;
	localparam int lines = 1 << index_bits;

	logic [tag_bits-1:0] tag_arr [lines];
	word_t data_arr [lines][4];
	logic [lines-1:0] valid_arr;
	logic [lines-1:0] dirty_arr;

	logic tag_match;
	logic do_write;
	word_t wr_word;

	assign valid = valid_arr[index];
	assign dirty = dirty_arr[index];
	assign tag_out = tag_arr[index];
	assign data_out = data_arr[index][offset[2:1]];

	assign tag_match = (tag_arr[index] == tag_in);
	assign hit = enable & comp & valid & tag_match;

	// Compare mode writes only on a hit, access mode always writes
	assign do_write = enable & write & (comp ? hit : 1'b1);
	assign wr_word = (!comp && data_src) ? fill_data : cpu_data;

	always_ff @(posedge clk) begin
		if (do_write) begin
			data_arr[index][offset[2:1]] <= wr_word;
			if (!comp)
				tag_arr[index] <= tag_in;	// Line is being filled
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			valid_arr <= '0;
			dirty_arr <= '0;
		end else if (do_write) begin
			if (comp) begin
				dirty_arr[index] <= 1'b1;	// CPU write hit
			end else begin
				valid_arr[index] <= 1'b1;
				dirty_arr[index] <= 1'b0;	// Fresh copy of memory
			end
		end
	end

	a_no_write_disabled: assert property (
		@(posedge clk) disable iff (reset)
		!enable |=> $stable(valid_arr) && $stable(dirty_arr)
	) else $error("cache_way written while disabled");

endmodule

`default_nettype wire

// File: source/cache_pkg.sv
`default_nettype none

package cache_pkg;

	// Controller sequence, fill states overlap the last two requests
	typedef enum logic [3:0] {
		idle,
		compare,
		select_way,
		wb_0,
		wb_1,
		wb_2,
		wb_3,
		req_0,
		req_1,
		req_2_fill_0,
		req_3_fill_1,
		fill_2,
		fill_3,
		finish
	} ctrl_state_t;

	// One-hot way enable, bit 0 is way 0
	typedef logic [1:0] way_sel_t;

	localparam way_sel_t way_none = 2'b00;
	localparam way_sel_t way_0 = 2'b01;
	localparam way_sel_t way_1 = 2'b10;
	localparam way_sel_t way_both = 2'b11;

endpackage

`default_nettype wire

// File: source/mem_pkg.sv
`default_nettype none

package mem_pkg;

	// Byte address, bits 2:0 offset, then index, then tag
	typedef logic [15:0] addr_t;

	// Data word on both the CPU and memory side
	typedef logic [15:0] word_t;

	// Byte offset inside a four-word line
	typedef logic [2:0] offset_t;

	// Bank number, taken from offset bits 2:1
	typedef logic [1:0] bank_t;

	// Row inside one bank, address bits 15:3
	typedef logic [12:0] row_t;

	// Read latency of the banked memory in cycles
	localparam int mem_latency = 2;

	// Words in each bank
	localparam int bank_rows = 8192;

endpackage

`default_nettype wire
